// File: rtl/conv_pkg.sv
package conv_pkg;

    ////////////////////////////////////////////////////////////
    // Array and datapath sizes
    ////////////////////////////////////////////////////////////

    parameter int BIT_WIDTH      = 8;
    parameter int NUM_CHANNEL    = 3;
    parameter int NUM_KERNEL     = 4;
    // Taps per window, one PE per tap
    parameter int KERNEL_SIZE    = 3;
    parameter int MAX_LINE_WIDTH = 64;
    parameter int LINE_CNT_WIDTH = $clog2(MAX_LINE_WIDTH + 1);

    parameter int PROD_WIDTH     = 2 * BIT_WIDTH;
    // 9 products of 255 x 255 still fit in 20 bits
    parameter int PSUM_WIDTH     = 20;

    ////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////

    // Channel 0 in the low bits
    typedef logic [NUM_CHANNEL-1:0][BIT_WIDTH-1:0] pixel_t;

    // Kernel 0 low, channel 0 low within each kernel
    typedef logic [NUM_KERNEL-1:0][NUM_CHANNEL-1:0][BIT_WIDTH-1:0] tap_weight_t;

    typedef logic [NUM_KERNEL-1:0][PSUM_WIDTH-1:0] psum_vec_t;
    typedef logic [NUM_KERNEL-1:0][PSUM_WIDTH-1:0] prod_vec_t;

    // Line controller states
    typedef enum logic [1:0] {
        IDLE,
        WAIT_WEIGHT,
        STREAM,
        DRAIN
    } ctrl_state_t;

endpackage

// File: rtl/weight_buffer.sv
`timescale 1ns/1ns

module weight_buffer (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 i_enable,
    input  conv_pkg::tap_weight_t                                i_weight,
    input  logic                                                 i_weight_val,
    output logic                                                 o_weight_req,
    output conv_pkg::tap_weight_t [conv_pkg::KERNEL_SIZE-1:0]    o_tap_weights,
    output logic                                                 o_weights_ready
);

    import conv_pkg::*;

    localparam int CNT_W = $clog2(KERNEL_SIZE + 1);

    logic [CNT_W-1:0] req_cnt;
    logic [CNT_W-1:0] rcv_cnt;
    logic             store_beat;

    // Requests stop the cycle enable falls
    assign o_weight_req    = i_enable && (req_cnt != CNT_W'(KERNEL_SIZE));
    assign o_weights_ready = (rcv_cnt == CNT_W'(KERNEL_SIZE));

    // A beat arriving in the first disabled cycle is dropped
    assign store_beat = i_weight_val && i_enable && !o_weights_ready;

    always_ff @(posedge clk) begin
        if (rst || !i_enable) begin
            req_cnt <= '0;
            rcv_cnt <= '0;
        end else begin
            if (o_weight_req) begin
                req_cnt <= req_cnt + 1'b1;
            end
            if (store_beat) begin
                rcv_cnt <= rcv_cnt + 1'b1;
            end
        end
    end

    // Beats come in tap order, so the receive count is the slot
    always_ff @(posedge clk) begin
        if (rst || !i_enable) begin
            o_tap_weights <= '0;
        end else if (store_beat) begin
            o_tap_weights[rcv_cnt] <= i_weight;
        end
    end

    // Full set loaded means the request side is finished too
    a_no_req_when_ready: assert property (
        @(posedge clk) disable iff (rst) o_weights_ready |-> !o_weight_req
    );

endmodule

// File: rtl/line_ctrl.sv
`timescale 1ns/1ns

module line_ctrl #(
    parameter int MAX_WIDTH = conv_pkg::MAX_LINE_WIDTH
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_enable,
    input  logic [conv_pkg::LINE_CNT_WIDTH-1:0] i_line_width,
    input  logic                                i_weights_ready,
    input  logic                                i_data_val,
    output logic                                o_data_req,
    output logic                                o_line_start,
    output logic                                o_line_last_pixel
);

    import conv_pkg::*;

    localparam logic [LINE_CNT_WIDTH-1:0] WIDTH_LIMIT = LINE_CNT_WIDTH'(MAX_WIDTH);

    ctrl_state_t               state;
    logic [LINE_CNT_WIDTH-1:0] width_q;
    logic [LINE_CNT_WIDTH-1:0] req_cnt;
    logic                      line_start_q;
    logic                      last_req_q;
    logic                      start_line;
    logic                      last_req;

    ////////////////////////////////////////////////////////////
    // Request generation
    ////////////////////////////////////////////////////////////

    assign start_line = i_enable && i_weights_ready &&
                        ((state == WAIT_WEIGHT) || (state == DRAIN));
    assign o_data_req = (state == STREAM) && i_enable;
    assign last_req   = o_data_req && (req_cnt == width_q - 1'b1);

    assign o_line_start      = line_start_q;
    // Pixel of the last request lands one cycle later
    assign o_line_last_pixel = i_data_val && last_req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            width_q      <= '0;
            req_cnt      <= '0;
            line_start_q <= 1'b0;
            last_req_q   <= 1'b0;
        end else begin
            line_start_q <= start_line;
            last_req_q   <= last_req;

            if (start_line) begin
                width_q <= (i_line_width > WIDTH_LIMIT) ? WIDTH_LIMIT : i_line_width;
                req_cnt <= '0;
            end else if (o_data_req) begin
                req_cnt <= req_cnt + 1'b1;
            end

            case (state)
                IDLE: begin
                    if (i_enable) begin
                        state <= WAIT_WEIGHT;
                    end
                end
                WAIT_WEIGHT, DRAIN: begin
                    if (!i_enable) begin
                        state <= IDLE;
                    end else if (start_line) begin
                        state <= STREAM;
                    end else begin
                        state <= WAIT_WEIGHT;
                    end
                end
                STREAM: begin
                    if (!i_enable) begin
                        state <= IDLE;
                    end else if (last_req) begin
                        state <= DRAIN;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Source must answer each request exactly one cycle later
    a_data_val_after_req: assert property (
        @(posedge clk) disable iff (rst) i_data_val |-> $past(o_data_req)
    );

endmodule

// File: rtl/input_window.sv
`timescale 1ns/1ns

module input_window (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          i_line_start,
    input  conv_pkg::pixel_t                              i_data,
    input  logic                                          i_data_val,
    input  logic                                          i_line_last_pixel,
    output conv_pkg::pixel_t [conv_pkg::KERNEL_SIZE-1:0]  o_window,
    output logic                                          o_window_val,
    output logic                                          o_window_last
);

    import conv_pkg::*;

    localparam int FILL_W = $clog2(KERNEL_SIZE + 1);

    logic [FILL_W-1:0] fill_cnt;
    logic              fills_window;

    // This pixel completes a window of the current line
    assign fills_window = i_data_val && !i_line_start &&
                          (fill_cnt >= FILL_W'(KERNEL_SIZE - 1));

    // Oldest pixel in tap 0, newest enters at the top
    always_ff @(posedge clk) begin
        if (i_data_val) begin
            o_window <= {i_data, o_window[KERNEL_SIZE-1:1]};
        end
    end

    ////////////////////////////////////////////////////////////
    // Fill tracking and position masking
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_cnt      <= '0;
            o_window_val  <= 1'b0;
            o_window_last <= 1'b0;
        end else begin
            o_window_val  <= fills_window;
            o_window_last <= fills_window && i_line_last_pixel;
            if (i_line_start) begin
                fill_cnt <= i_data_val ? FILL_W'(1) : '0;
            end else if (i_data_val && (fill_cnt != FILL_W'(KERNEL_SIZE))) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

endmodule

// File: rtl/kernel_channel_pe.sv
`timescale 1ns/1ns

module kernel_channel_pe (
    input  logic                  clk,
    input  logic                  rst,
    input  conv_pkg::pixel_t      i_pixel,
    input  conv_pkg::tap_weight_t i_weight,
    input  logic                  i_val,
    input  logic                  i_last,
    output conv_pkg::prod_vec_t   o_prod,
    output logic                  o_prod_val,
    output logic                  o_prod_last
);

    import conv_pkg::*;

    logic [PROD_WIDTH-1:0] mult [NUM_KERNEL][NUM_CHANNEL];
    prod_vec_t             dot;

    // Channel dot product of one pixel per kernel
    always_comb begin
        for (int k = 0; k < NUM_KERNEL; k++) begin
            dot[k] = '0;
            for (int c = 0; c < NUM_CHANNEL; c++) begin
                mult[k][c] = i_pixel[c] * i_weight[k][c];
                dot[k]     = dot[k] + PSUM_WIDTH'(mult[k][c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_val) begin
            o_prod <= dot;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_prod_val  <= 1'b0;
            o_prod_last <= 1'b0;
        end else begin
            o_prod_val  <= i_val;
            o_prod_last <= i_val && i_last;
        end
    end

endmodule

// File: rtl/psum_reducer.sv
`timescale 1ns/1ns

module psum_reducer (
    input  logic                                            clk,
    input  logic                                            rst,
    input  conv_pkg::prod_vec_t [conv_pkg::KERNEL_SIZE-1:0] i_prods,
    input  logic [conv_pkg::KERNEL_SIZE-1:0]                i_val,
    input  logic [conv_pkg::KERNEL_SIZE-1:0]                i_last,
    output conv_pkg::psum_vec_t                             o_psum,
    output logic                                            o_psum_val,
    output logic                                            o_psum_end
);

    import conv_pkg::*;

    psum_vec_t sum;
    logic      all_val;

    assign all_val = &i_val;

    // Sum across taps, per kernel
    always_comb begin
        for (int k = 0; k < NUM_KERNEL; k++) begin
            sum[k] = '0;
            for (int t = 0; t < KERNEL_SIZE; t++) begin
                sum[k] = sum[k] + i_prods[t][k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (all_val) begin
            o_psum <= sum;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_psum_val <= 1'b0;
            o_psum_end <= 1'b0;
        end else begin
            o_psum_val <= all_val;
            o_psum_end <= all_val && (&i_last);
        end
    end

    a_end_with_val: assert property (
        @(posedge clk) disable iff (rst) o_psum_end |-> o_psum_val
    );

endmodule

// File: rtl/line_conv_engine.sv
`timescale 1ns/1ns

module line_conv_engine #(
    parameter int MAX_WIDTH = conv_pkg::MAX_LINE_WIDTH
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_enable,
    input  logic [conv_pkg::LINE_CNT_WIDTH-1:0] i_line_width,
    input  conv_pkg::tap_weight_t               i_weight,
    input  logic                                i_weight_val,
    input  conv_pkg::pixel_t                    i_data,
    input  logic                                i_data_val,
    output logic                                o_weight_req,
    output logic                                o_data_req,
    output conv_pkg::psum_vec_t                 o_psum,
    output logic                                o_psum_val,
    output logic                                o_psum_end
);

    import conv_pkg::*;

    tap_weight_t [KERNEL_SIZE-1:0] tap_weights;
    logic                          weights_ready;
    logic                          line_start;
    logic                          line_last_pixel;
    pixel_t [KERNEL_SIZE-1:0]      window;
    logic                          window_val;
    logic                          window_last;
    prod_vec_t [KERNEL_SIZE-1:0]   prods;
    logic [KERNEL_SIZE-1:0]        prod_val;
    logic [KERNEL_SIZE-1:0]        prod_last;

    ////////////////////////////////////////////////////////////
    // Fetch side
    ////////////////////////////////////////////////////////////

    weight_buffer u_weight_buffer (
        .clk             (clk),
        .rst             (rst),
        .i_enable        (i_enable),
        .i_weight        (i_weight),
        .i_weight_val    (i_weight_val),
        .o_weight_req    (o_weight_req),
        .o_tap_weights   (tap_weights),
        .o_weights_ready (weights_ready)
    );

    line_ctrl #(
        .MAX_WIDTH (MAX_WIDTH)
    ) u_line_ctrl (
        .clk               (clk),
        .rst               (rst),
        .i_enable          (i_enable),
        .i_line_width      (i_line_width),
        .i_weights_ready   (weights_ready),
        .i_data_val        (i_data_val),
        .o_data_req        (o_data_req),
        .o_line_start      (line_start),
        .o_line_last_pixel (line_last_pixel)
    );

    input_window u_input_window (
        .clk               (clk),
        .rst               (rst),
        .i_line_start      (line_start),
        .i_data            (i_data),
        .i_data_val        (i_data_val),
        .i_line_last_pixel (line_last_pixel),
        .o_window          (window),
        .o_window_val      (window_val),
        .o_window_last     (window_last)
    );

    ////////////////////////////////////////////////////////////
    // PE array and reduction
    ////////////////////////////////////////////////////////////

    for (genvar t = 0; t < KERNEL_SIZE; t++) begin : g_pe
        kernel_channel_pe u_pe (
            .clk         (clk),
            .rst         (rst),
            .i_pixel     (window[t]),
            .i_weight    (tap_weights[t]),
            .i_val       (window_val),
            .i_last      (window_last),
            .o_prod      (prods[t]),
            .o_prod_val  (prod_val[t]),
            .o_prod_last (prod_last[t])
        );
    end

    psum_reducer u_psum_reducer (
        .clk        (clk),
        .rst        (rst),
        .i_prods    (prods),
        .i_val      (prod_val),
        .i_last     (prod_last),
        .o_psum     (o_psum),
        .o_psum_val (o_psum_val),
        .o_psum_end (o_psum_end)
    );

endmodule

// File: test/tb_line_conv_engine.sv
`timescale 1ns/1ns

module tb_line_conv_engine;

    import conv_pkg::*;

    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 16;
    localparam int          IDLE_CYCLES  = 50;
    localparam logic [31:0] SEED         = 32'hc774d163;
    localparam int          T3_LINES     = 5;
    localparam int          T3_WIDTH     = 16;
    localparam int          T4_WIDTH     = 10;
    localparam int          T6_WIDTH     = 12;
    localparam int          TOTAL_PIXELS = 8 + T3_LINES * T3_WIDTH + T4_WIDTH
                                         + KERNEL_SIZE + 20 + MAX_LINE_WIDTH + 2 * T6_WIDTH;
    localparam int          MARGIN_NS    = (RESET_CYCLES + IDLE_CYCLES) * CLK_PERIOD + 2000;
    localparam int          TIMEOUT_NS   = TOTAL_PIXELS * CLK_PERIOD * 4 + MARGIN_NS;
    localparam int          DRAIN_CYCLES = 20;
    // Every product at 255 x 255
    localparam int          MAX_PSUM     = KERNEL_SIZE * NUM_CHANNEL * 255 * 255;

    // Stimulus value modes
    localparam int PATTERN = 0;
    localparam int RANDOM  = 1;
    localparam int FULL    = 2;

    logic                      clk;
    logic                      rst;
    logic                      i_enable;
    logic [LINE_CNT_WIDTH-1:0] i_line_width;
    tap_weight_t               i_weight;
    logic                      i_weight_val;
    pixel_t                    i_data;
    logic                      i_data_val;
    logic                      o_weight_req;
    logic                      o_data_req;
    psum_vec_t                 o_psum;
    logic                      o_psum_val;
    logic                      o_psum_end;

    tap_weight_t ref_w [KERNEL_SIZE];
    pixel_t      line_pix [MAX_LINE_WIDTH];
    tap_weight_t wgt_q [$];
    pixel_t      pix_q [$];
    int          width_q [$];
    psum_vec_t   exp_psum_q [$];
    logic        exp_end_q [$];
    logic        stream_done;
    int          pix_in_line;
    int          weight_req_cnt;
    int          out_cnt;
    int          err_cnt;
    int          test_cnt;
    int          test_out_base;
    int          test_err_base;
    int unsigned rnd;

    line_conv_engine #(
        .MAX_WIDTH (MAX_LINE_WIDTH)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .i_enable     (i_enable),
        .i_line_width (i_line_width),
        .i_weight     (i_weight),
        .i_weight_val (i_weight_val),
        .i_data       (i_data),
        .i_data_val   (i_data_val),
        .o_weight_req (o_weight_req),
        .o_data_req   (o_data_req),
        .o_psum       (o_psum),
        .o_psum_val   (o_psum_val),
        .o_psum_end   (o_psum_end)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Fetch sources, answer one cycle after each request
    ////////////////////////////////////////////////////////////

    initial begin : weight_source
        logic req_seen;
        i_weight       = '0;
        i_weight_val   = 1'b0;
        weight_req_cnt = 0;
        forever begin
            @(negedge clk);
            req_seen = o_weight_req;
            @(posedge clk);
            #1;
            i_weight_val = 1'b0;
            if (req_seen) begin
                weight_req_cnt++;
                if (wgt_q.size() == 0) begin
                    $display("Weight request at %0t ns with no weight beat left", $time);
                    err_cnt++;
                end else begin
                    i_weight     = wgt_q.pop_front();
                    i_weight_val = 1'b1;
                end
            end
        end
    end

    initial begin : data_source
        logic req_seen;
        i_data      = '0;
        i_data_val  = 1'b0;
        pix_in_line = 0;
        stream_done = 1'b0;
        forever begin
            @(negedge clk);
            req_seen = o_data_req;
            @(posedge clk);
            #1;
            i_data_val = 1'b0;
            if (req_seen) begin
                if (pix_q.size() == 0 || width_q.size() == 0) begin
                    $display("Pixel request at %0t ns with no pixel left", $time);
                    err_cnt++;
                end else begin
                    i_data     = pix_q.pop_front();
                    i_data_val = 1'b1;
                    pix_in_line++;
                    // Next width is latched on the edge after a line's last pixel
                    if (pix_in_line == width_q[0]) begin
                        width_q.delete(0);
                        pix_in_line = 0;
                        if (width_q.size() != 0) begin
                            i_line_width = LINE_CNT_WIDTH'(width_q[0]);
                        end else begin
                            stream_done = 1'b1;
                        end
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [BIT_WIDTH-1:0] gen_value(input int mode, input int a, input int b);
        case (mode)
            PATTERN: return BIT_WIDTH'(a + b + 1);
            RANDOM:  return BIT_WIDTH'($urandom);
            default: return '1;
        endcase
    endfunction

    // Window starting at pixel base, tap 0 on the oldest pixel
    function automatic psum_vec_t ref_psum(input int base);
        psum_vec_t acc;
        acc = '0;
        for (int k = 0; k < NUM_KERNEL; k++) begin
            for (int t = 0; t < KERNEL_SIZE; t++) begin
                for (int c = 0; c < NUM_CHANNEL; c++) begin
                    acc[k] = acc[k] + PSUM_WIDTH'(line_pix[base + t][c])
                                    * PSUM_WIDTH'(ref_w[t][k][c]);
                end
            end
        end
        return acc;
    endfunction

    task automatic load_weights(input int mode);
        for (int t = 0; t < KERNEL_SIZE; t++) begin
            for (int k = 0; k < NUM_KERNEL; k++) begin
                for (int c = 0; c < NUM_CHANNEL; c++) begin
                    ref_w[t][k][c] = gen_value(mode, t + k, c);
                end
            end
            wgt_q.push_back(ref_w[t]);
        end
    endtask

    task automatic add_line(input int width, input int mode);
        for (int i = 0; i < width; i++) begin
            for (int c = 0; c < NUM_CHANNEL; c++) begin
                line_pix[i][c] = gen_value(mode, i, c);
            end
            pix_q.push_back(line_pix[i]);
        end
        width_q.push_back(width);
        for (int b = 0; b <= width - KERNEL_SIZE; b++) begin
            exp_psum_q.push_back(ref_psum(b));
            exp_end_q.push_back(b == width - KERNEL_SIZE);
        end
    endtask

    always @(negedge clk) begin : compare
        psum_vec_t exp_psum;
        logic      exp_end;
        if (!rst && o_psum_val) begin
            assert (exp_psum_q.size() != 0) else begin
                $display("Output at %0t ns arrived with no result expected", $time);
                err_cnt++;
            end
            if (exp_psum_q.size() != 0) begin
                exp_psum = exp_psum_q.pop_front();
                exp_end  = exp_end_q.pop_front();
                out_cnt++;
                assert (o_psum == exp_psum) else begin
                    $display("Error at %0t ns: psum %h, expected %h", $time, o_psum, exp_psum);
                    err_cnt++;
                end
                assert (o_psum_end == exp_end) else begin
                    $display("Error at %0t ns: line end %b, expected %b",
                             $time, o_psum_end, exp_end);
                    err_cnt++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequencing
    ////////////////////////////////////////////////////////////

    task automatic drain_outputs;
        int cycles;
        cycles = 0;
        while (exp_psum_q.size() != 0 && cycles < DRAIN_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        // A few more cycles to catch extra outputs
        repeat (4) @(posedge clk);
        assert (exp_psum_q.size() == 0) else begin
            $display("%0d expected outputs never appeared", exp_psum_q.size());
            err_cnt++;
            exp_psum_q.delete();
            exp_end_q.delete();
        end
    endtask

    task automatic run_stream;
        stream_done    = 1'b0;
        weight_req_cnt = 0;
        @(posedge clk);
        #1;
        i_line_width = LINE_CNT_WIDTH'(width_q[0]);
        i_enable     = 1'b1;
        while (!stream_done) begin
            @(posedge clk);
        end
        // Enable stays up one more cycle so the last window still has its weights
        #1;
        i_enable = 1'b0;
        drain_outputs();
    endtask

    task automatic check_out_count(input int expected);
        assert (out_cnt - test_out_base == expected) else begin
            $display("Error at %0t ns: %0d outputs, expected %0d",
                     $time, out_cnt - test_out_base, expected);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("Test %0d (%s) done: %0d outputs, %0d errors",
                 test_cnt, name, out_cnt - test_out_base, err_cnt - test_err_base);
        test_out_base = out_cnt;
        test_err_base = err_cnt;
    endtask

    initial begin : main
        psum_vec_t full_psum;
        rst           = 1'b1;
        i_enable      = 1'b0;
        i_line_width  = '0;
        out_cnt       = 0;
        err_cnt       = 0;
        test_cnt      = 0;
        test_out_base = 0;
        test_err_base = 0;
        rnd           = $urandom(SEED);
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            assert (!o_weight_req && !o_data_req && !o_psum_val && !o_psum_end) else begin
                $display("Error at %0t ns: activity while disabled", $time);
                err_cnt++;
            end
        end
        finish_test("idle after reset");

        load_weights(PATTERN);
        add_line(8, PATTERN);
        run_stream();
        check_out_count(8 - KERNEL_SIZE + 1);
        finish_test("single line of 8");

        load_weights(RANDOM);
        for (int n = 0; n < T3_LINES; n++) begin
            add_line(T3_WIDTH, RANDOM);
        end
        run_stream();
        check_out_count(T3_LINES * (T3_WIDTH - KERNEL_SIZE + 1));
        finish_test("back-to-back random lines");

        load_weights(FULL);
        add_line(T4_WIDTH, FULL);
        full_psum = ref_psum(0);
        for (int k = 0; k < NUM_KERNEL; k++) begin
            assert (full_psum[k] == PSUM_WIDTH'(MAX_PSUM)) else begin
                $display("Error at %0t ns: full-scale model sum is wrong", $time);
                err_cnt++;
            end
        end
        run_stream();
        check_out_count(T4_WIDTH - KERNEL_SIZE + 1);
        finish_test("full-scale values");

        load_weights(RANDOM);
        add_line(KERNEL_SIZE, RANDOM);
        add_line(20, RANDOM);
        add_line(MAX_LINE_WIDTH, RANDOM);
        run_stream();
        check_out_count(1 + (20 - KERNEL_SIZE + 1) + (MAX_LINE_WIDTH - KERNEL_SIZE + 1));
        finish_test("widths 3, 20 and 64");

        load_weights(RANDOM);
        add_line(T6_WIDTH, RANDOM);
        run_stream();
        load_weights(PATTERN);
        add_line(T6_WIDTH, RANDOM);
        run_stream();
        assert (weight_req_cnt == KERNEL_SIZE) else begin
            $display("Error at %0t ns: %0d weight requests, expected %0d",
                     $time, weight_req_cnt, KERNEL_SIZE);
            err_cnt++;
        end
        finish_test("weight reload");

        $display("%0d tests, %0d outputs checked, %0d errors", test_cnt, out_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
rtl/conv_pkg.sv
rtl/weight_buffer.sv
rtl/line_ctrl.sv
rtl/input_window.sv
rtl/kernel_channel_pe.sv
rtl/psum_reducer.sv
rtl/line_conv_engine.sv
test/tb_line_conv_engine.sv
